//--- rtl/ecgDataPkg.sv
`default_nettype none

package ecgDataPkg;

	// Sample words and record layout of the beat table.
	localparam int SAMPLE_WIDTH       = 14;
	localparam int SAMPLES_PER_BEAT   = 75;
	localparam int NUM_RECORDS        = 2;
	localparam int SAMPLE_INDEX_WIDTH = 7;
	localparam int RECORD_WIDTH       = 1;
	localparam int ROM_ADDR_WIDTH     = 8;
	localparam int ROM_DEPTH          = NUM_RECORDS * SAMPLES_PER_BEAT;

endpackage

`default_nettype wire

//--- rtl/ecgClassPkg.sv
`default_nettype none

package ecgClassPkg;

	typedef enum logic [1:0] {
		CLASS_NORMAL,
		CLASS_HIGH_AMPLITUDE,
		CLASS_SHIFTED_PEAK
	} beatClass_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_RUN,
		SEQ_DRAIN
	} seqState_t;

	localparam int AMPLITUDE_WIDTH = 14;

endpackage

`default_nettype wire

//--- rtl/beatRom.sv
`timescale 1ns/1ns
`default_nettype none

module beatRom (
	input  logic                                  clk,
	input  logic [ecgDataPkg::ROM_ADDR_WIDTH-1:0] romAddr,
	output logic [ecgDataPkg::SAMPLE_WIDTH-1:0]   romData
);

	logic [ecgDataPkg::SAMPLE_WIDTH-1:0] mem [0:ecgDataPkg::ROM_DEPTH-1];

	// Records stored back to back, 75 words each.
	initial begin
		$readmemh("rtl/beatRecords.hex", mem);
	end

	always_ff @(posedge clk) begin
		romData <= mem[romAddr];
	end

endmodule

`default_nettype wire

//--- rtl/sampleSequencer.sv
`timescale 1ns/1ns
`default_nettype none

module sampleSequencer (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      start,
	input  logic [ecgDataPkg::RECORD_WIDTH-1:0]       recordSelect,
	input  logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0]   ampThresholdIn,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakLowIn,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakHighIn,
	input  logic                                      resultValid,
	output logic                                      busy,
	output logic [ecgDataPkg::ROM_ADDR_WIDTH-1:0]     romAddr,
	output logic                                      sampleStrobe,
	output logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] sampleIndex,
	output logic                                      lastSample,
	output logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0]   ampThreshold,
	output logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakLow,
	output logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakHigh
);

	localparam int AW = ecgDataPkg::ROM_ADDR_WIDTH;
	localparam int IW = ecgDataPkg::SAMPLE_INDEX_WIDTH;
	localparam logic [IW-1:0] LAST_INDEX = IW'(ecgDataPkg::SAMPLES_PER_BEAT - 1);

	ecgClassPkg::seqState_t state;
	logic [IW-1:0] index;
	logic [ecgDataPkg::RECORD_WIDTH-1:0] recordHeld;
	logic [AW-1:0] recordBase;
	logic issueValid;
	logic issueLast;
	logic [IW-1:0] issueIndex;
	logic accept;

	// Busy drops together with the result pulse.
	assign busy = (state != ecgClassPkg::SEQ_IDLE) &&
		!((state == ecgClassPkg::SEQ_DRAIN) && resultValid);
	assign accept = start && !busy;
	assign recordBase = AW'(recordHeld) * AW'(ecgDataPkg::SAMPLES_PER_BEAT);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ecgClassPkg::SEQ_IDLE;
		end else if (accept) begin
			state <= ecgClassPkg::SEQ_RUN;
		end else if (state == ecgClassPkg::SEQ_RUN && index == LAST_INDEX) begin
			state <= ecgClassPkg::SEQ_DRAIN;
		end else if (state == ecgClassPkg::SEQ_DRAIN && resultValid) begin
			state <= ecgClassPkg::SEQ_IDLE;
		end
	end

	// Beat settings held for the whole beat.
	always_ff @(posedge clk) begin
		if (accept) begin
			recordHeld <= recordSelect;
			ampThreshold <= ampThresholdIn;
			peakLow <= peakLowIn;
			peakHigh <= peakHighIn;
			index <= '0;
		end else if (state == ecgClassPkg::SEQ_RUN) begin
			index <= index + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		romAddr <= recordBase + AW'(index);
		issueIndex <= index;
		sampleIndex <= issueIndex;
	end

	// Strobes trail the address by one cycle to meet the ROM data.
	always_ff @(posedge clk) begin
		if (reset) begin
			issueValid <= 1'b0;
			issueLast <= 1'b0;
			sampleStrobe <= 1'b0;
			lastSample <= 1'b0;
		end else begin
			issueValid <= state == ecgClassPkg::SEQ_RUN;
			issueLast <= (state == ecgClassPkg::SEQ_RUN) && (index == LAST_INDEX);
			sampleStrobe <= issueValid;
			lastSample <= issueLast;
		end
	end

endmodule

`default_nettype wire

//--- rtl/featureExtractor.sv
`timescale 1ns/1ns
`default_nettype none

module featureExtractor #(
	parameter int SKIP_SAMPLES = 4
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic [ecgDataPkg::SAMPLE_WIDTH-1:0]       romData,
	input  logic                                      sampleStrobe,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] sampleIndex,
	input  logic                                      lastSample,
	output logic                                      featuresDone,
	output logic [ecgDataPkg::SAMPLE_WIDTH-1:0]       maxValue,
	output logic [ecgDataPkg::SAMPLE_WIDTH-1:0]       minValue,
	output logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] maxIndex
);

	localparam int IW = ecgDataPkg::SAMPLE_INDEX_WIDTH;
	localparam logic [IW-1:0] SKIP_INDEX = IW'(SKIP_SAMPLES);

	logic counted;
	logic firstSample;

	// Leading samples carry the calibration marker.
	assign counted = sampleStrobe && (sampleIndex >= SKIP_INDEX);
	assign firstSample = sampleIndex == SKIP_INDEX;

	// Strictly greater keeps the earliest peak on a tie.
	always_ff @(posedge clk) begin
		if (counted) begin
			if (firstSample || romData > maxValue) begin
				maxValue <= romData;
				maxIndex <= sampleIndex;
			end
			if (firstSample || romData < minValue) begin
				minValue <= romData;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			featuresDone <= 1'b0;
		end else begin
			featuresDone <= sampleStrobe && lastSample;
		end
	end

endmodule

`default_nettype wire

//--- rtl/beatClassifier.sv
`timescale 1ns/1ns
`default_nettype none

module beatClassifier (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      featuresDone,
	input  logic [ecgDataPkg::SAMPLE_WIDTH-1:0]       maxValue,
	input  logic [ecgDataPkg::SAMPLE_WIDTH-1:0]       minValue,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] maxIndex,
	input  logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0]   ampThreshold,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakLow,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakHigh,
	output logic                                      resultValid,
	output ecgClassPkg::beatClass_t                   beatClass,
	output logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0]   peakAmplitude,
	output logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakIndex
);

	logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0] amplitude;
	ecgClassPkg::beatClass_t nextClass;

	assign amplitude = maxValue - minValue;

	// Amplitude check wins over the peak position.
	always_comb begin
		if (amplitude >= ampThreshold) begin
			nextClass = ecgClassPkg::CLASS_HIGH_AMPLITUDE;
		end else if (maxIndex < peakLow || maxIndex > peakHigh) begin
			nextClass = ecgClassPkg::CLASS_SHIFTED_PEAK;
		end else begin
			nextClass = ecgClassPkg::CLASS_NORMAL;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			resultValid <= 1'b0;
			beatClass <= ecgClassPkg::CLASS_NORMAL;
		end else begin
			resultValid <= featuresDone;
			if (featuresDone) begin
				beatClass <= nextClass;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (featuresDone) begin
			peakAmplitude <= amplitude;
			peakIndex <= maxIndex;
		end
	end

endmodule

`default_nettype wire

//--- rtl/ecgBeatTop.sv
`timescale 1ns/1ns
`default_nettype none

module ecgBeatTop #(
	parameter int SKIP_SAMPLES = 4
) (
	input  logic                                      clk,
	input  logic                                      reset,
	input  logic                                      start,
	input  logic [ecgDataPkg::RECORD_WIDTH-1:0]       recordSelect,
	input  logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0]   ampThreshold,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakLow,
	input  logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakHigh,
	output logic                                      busy,
	output logic                                      resultValid,
	output ecgClassPkg::beatClass_t                   beatClass,
	output logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0]   peakAmplitude,
	output logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakIndex
);

	logic [ecgDataPkg::ROM_ADDR_WIDTH-1:0] romAddr;
	logic [ecgDataPkg::SAMPLE_WIDTH-1:0] romData;
	logic sampleStrobe;
	logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] sampleIndex;
	logic lastSample;
	logic [ecgClassPkg::AMPLITUDE_WIDTH-1:0] ampThresholdHeld;
	logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakLowHeld;
	logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] peakHighHeld;
	logic featuresDone;
	logic [ecgDataPkg::SAMPLE_WIDTH-1:0] maxValue;
	logic [ecgDataPkg::SAMPLE_WIDTH-1:0] minValue;
	logic [ecgDataPkg::SAMPLE_INDEX_WIDTH-1:0] maxIndex;

	sampleSequencer sampleSequencer_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.recordSelect(recordSelect),
		.ampThresholdIn(ampThreshold),
		.peakLowIn(peakLow),
		.peakHighIn(peakHigh),
		.resultValid(resultValid),
		.busy(busy),
		.romAddr(romAddr),
		.sampleStrobe(sampleStrobe),
		.sampleIndex(sampleIndex),
		.lastSample(lastSample),
		.ampThreshold(ampThresholdHeld),
		.peakLow(peakLowHeld),
		.peakHigh(peakHighHeld)
	);

	beatRom beatRom_inst (
		.clk(clk),
		.romAddr(romAddr),
		.romData(romData)
	);

	featureExtractor #(
		.SKIP_SAMPLES(SKIP_SAMPLES)
	) featureExtractor_inst (
		.clk(clk),
		.reset(reset),
		.romData(romData),
		.sampleStrobe(sampleStrobe),
		.sampleIndex(sampleIndex),
		.lastSample(lastSample),
		.featuresDone(featuresDone),
		.maxValue(maxValue),
		.minValue(minValue),
		.maxIndex(maxIndex)
	);

	beatClassifier beatClassifier_inst (
		.clk(clk),
		.reset(reset),
		.featuresDone(featuresDone),
		.maxValue(maxValue),
		.minValue(minValue),
		.maxIndex(maxIndex),
		.ampThreshold(ampThresholdHeld),
		.peakLow(peakLowHeld),
		.peakHigh(peakHighHeld),
		.resultValid(resultValid),
		.beatClass(beatClass),
		.peakAmplitude(peakAmplitude),
		.peakIndex(peakIndex)
	);

endmodule

`default_nettype wire

//--- verif/ecgBeatTb.sv
`timescale 1ns/1ns
`default_nettype none

module ecgBeatTb;

	localparam int SKIP = 4;
	localparam int NUM_ROWS = 9;
	localparam int LATENCY = 78;
	localparam int CYCLE_LIMIT = NUM_ROWS * 90 + 50;
	localparam int IW = ecgDataPkg::SAMPLE_INDEX_WIDTH;
	localparam int AMW = ecgClassPkg::AMPLITUDE_WIDTH;

	logic clk;
	logic reset;
	logic start;
	logic [ecgDataPkg::RECORD_WIDTH-1:0] recordSelect;
	logic [AMW-1:0] ampThreshold;
	logic [IW-1:0] peakLow;
	logic [IW-1:0] peakHigh;
	logic busy;
	logic resultValid;
	ecgClassPkg::beatClass_t beatClass;
	logic [AMW-1:0] peakAmplitude;
	logic [IW-1:0] peakIndex;

	logic [ecgDataPkg::SAMPLE_WIDTH-1:0] romImage [0:ecgDataPkg::ROM_DEPTH-1];

	int rowRecord [NUM_ROWS];
	int rowThreshold [NUM_ROWS];
	int rowLow [NUM_ROWS];
	int rowHigh [NUM_ROWS];
	bit rowExtraStart [NUM_ROWS];
	bit rowRandom [NUM_ROWS];
	ecgClassPkg::beatClass_t rowClass [NUM_ROWS];

	int seed;
	int valueErrors;
	int missingResults;
	int cycleCount;

	ecgBeatTop #(
		.SKIP_SAMPLES(SKIP)
	) ecgBeatTop_inst (
		.clk(clk),
		.reset(reset),
		.start(start),
		.recordSelect(recordSelect),
		.ampThreshold(ampThreshold),
		.peakLow(peakLow),
		.peakHigh(peakHigh),
		.busy(busy),
		.resultValid(resultValid),
		.beatClass(beatClass),
		.peakAmplitude(peakAmplitude),
		.peakIndex(peakIndex)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < CYCLE_LIMIT) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
		$display("Simulation FAILED");
		$finish;
	end

	task automatic reportMismatch(input int row, input string what, input int got, input int want);
		$display("Fail %0t: row %0d %s is %0d, expected %0d", $time, row, what, got, want);
		valueErrors++;
	endtask

	task automatic setRow(input int i, input int rec, input int thr, input int lo, input int hi,
			input bit extra, input ecgClassPkg::beatClass_t cls);
		rowRecord[i] = rec;
		rowThreshold[i] = thr;
		rowLow[i] = lo;
		rowHigh[i] = hi;
		rowExtraStart[i] = extra;
		rowRandom[i] = 1'b0;
		rowClass[i] = cls;
	endtask

	// Expected classes worked out from the features of each record.
	task automatic loadTable();
		logic [31:0] r;
		setRow(0, 0, 3000, 10, 60, 1'b0, ecgClassPkg::CLASS_NORMAL);
		setRow(1, 1, 2000, 50, 60, 1'b0, ecgClassPkg::CLASS_HIGH_AMPLITUDE);
		setRow(2, 0, 3000, 35, 50, 1'b0, ecgClassPkg::CLASS_SHIFTED_PEAK);
		setRow(3, 0, 3000, 10, 60, 1'b1, ecgClassPkg::CLASS_NORMAL);
		setRow(4, 1, 3000, 10, 40, 1'b0, ecgClassPkg::CLASS_SHIFTED_PEAK);
		setRow(5, 1, 2290, 0, 74, 1'b0, ecgClassPkg::CLASS_HIGH_AMPLITUDE);
		for (int i = 6; i < NUM_ROWS; i++) begin
			r = $random(seed);
			setRow(i, i % 2, 1000 + (int'(r[14:0]) % 1600), 20 + int'(r[19:15]), 0, 1'b0,
				ecgClassPkg::CLASS_NORMAL);
			rowHigh[i] = rowLow[i] + 5 + int'(r[23:20]);
			rowRandom[i] = 1'b1;
		end
	endtask

	// Reference features straight from the classification rule.
	task automatic computeModel(input int rec, input int thr, input int lo, input int hi,
			output int peak, output int peakPos, output int trough,
			output ecgClassPkg::beatClass_t cls);
		int value;
		peak = 0;
		peakPos = 0;
		trough = 0;
		for (int i = SKIP; i < ecgDataPkg::SAMPLES_PER_BEAT; i++) begin
			value = int'(romImage[rec * ecgDataPkg::SAMPLES_PER_BEAT + i]);
			if (i == SKIP || value > peak) begin
				peak = value;
				peakPos = i;
			end
			if (i == SKIP || value < trough) begin
				trough = value;
			end
		end
		if (peak - trough >= thr) begin
			cls = ecgClassPkg::CLASS_HIGH_AMPLITUDE;
		end else if (peakPos < lo || peakPos > hi) begin
			cls = ecgClassPkg::CLASS_SHIFTED_PEAK;
		end else begin
			cls = ecgClassPkg::CLASS_NORMAL;
		end
	endtask

	task automatic runBeat(input int row);
		int expPeak;
		int expPos;
		int expTrough;
		int latency;
		ecgClassPkg::beatClass_t expClass;
		computeModel(rowRecord[row], rowThreshold[row], rowLow[row], rowHigh[row],
			expPeak, expPos, expTrough, expClass);
		if (row == 0 && (expPeak != 2760 || expPos != 31 || expTrough != 1302)) begin
			reportMismatch(row, "record 0 model peak", expPeak, 2760);
		end
		if (rowRandom[row]) begin
			rowClass[row] = expClass;
		end else if (expClass != rowClass[row]) begin
			reportMismatch(row, "model class vs table", int'(expClass), int'(rowClass[row]));
		end

		@(posedge clk);
		#1;
		start = 1'b1;
		recordSelect = 1'(rowRecord[row]);
		ampThreshold = AMW'(rowThreshold[row]);
		peakLow = IW'(rowLow[row]);
		peakHigh = IW'(rowHigh[row]);
		@(posedge clk);
		#1;
		start = 1'b0;
		latency = 0;
		while (!resultValid && latency <= LATENCY + 10) begin
			if (!busy) begin
				reportMismatch(row, "busy during beat", int'(busy), 1);
			end
			@(posedge clk);
			#1;
			latency++;
			start = rowExtraStart[row] && latency == 20;
			if (rowExtraStart[row] && latency == 20) begin
				// Settings that would flip the class if they were taken.
				recordSelect = 1'(1 - rowRecord[row]);
				ampThreshold = '0;
				peakLow = '0;
				peakHigh = '1;
			end
		end
		if (!resultValid) begin
			$display("Row %0d: resultValid never came after the start pulse.", row);
			missingResults++;
		end else begin
			if (latency != LATENCY) begin
				reportMismatch(row, "start to result latency", latency, LATENCY);
			end
			if (busy) begin
				reportMismatch(row, "busy at result", int'(busy), 0);
			end
			if (beatClass != expClass) begin
				reportMismatch(row, "beatClass", int'(beatClass), int'(expClass));
			end
			if (int'(peakAmplitude) != expPeak - expTrough) begin
				reportMismatch(row, "peakAmplitude", int'(peakAmplitude), expPeak - expTrough);
			end
			if (int'(peakIndex) != expPos) begin
				reportMismatch(row, "peakIndex", int'(peakIndex), expPos);
			end
		end

		// Quiet gap with held outputs and no second pulse.
		repeat (4) begin
			@(posedge clk);
			#1;
			if (resultValid || busy) begin
				reportMismatch(row, "resultValid or busy after result", 1, 0);
			end
			if (beatClass != expClass) begin
				reportMismatch(row, "held beatClass", int'(beatClass), int'(expClass));
			end
			if (int'(peakAmplitude) != expPeak - expTrough) begin
				reportMismatch(row, "held peakAmplitude", int'(peakAmplitude),
					expPeak - expTrough);
			end
			if (int'(peakIndex) != expPos) begin
				reportMismatch(row, "held peakIndex", int'(peakIndex), expPos);
			end
		end
	endtask

	initial begin
		seed = 32'h2fdf_2ae6;
		valueErrors = 0;
		missingResults = 0;
		reset = 1'b1;
		start = 1'b0;
		recordSelect = '0;
		ampThreshold = '0;
		peakLow = '0;
		peakHigh = '0;
		$readmemh("rtl/beatRecords.hex", romImage);
		loadTable();

		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		if (resultValid || busy) begin
			reportMismatch(-1, "resultValid or busy after reset", 1, 0);
		end
		if (beatClass != ecgClassPkg::CLASS_NORMAL) begin
			reportMismatch(-1, "beatClass after reset", int'(beatClass), 0);
		end

		for (int row = 0; row < NUM_ROWS; row++) begin
			runBeat(row);
		end

		$display("Value errors: %0d, missing results: %0d", valueErrors, missingResults);
		if (valueErrors == 0 && missingResults == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
rtl/ecgDataPkg.sv
rtl/ecgClassPkg.sv
rtl/beatRom.sv
rtl/sampleSequencer.sv
rtl/featureExtractor.sv
rtl/beatClassifier.sv
rtl/ecgBeatTop.sv
verif/ecgBeatTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the ECG beat testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -Wno-fatal -f list.f \
	--top-module ecgBeatTb -Mdir obj_dir -o ecgBeatSim
./obj_dir/ecgBeatSim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
	echo "run.sh: failure reported in sim.log"
	exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
	echo "run.sh: no pass line found in sim.log"
	exit 1
fi
echo "run.sh: done"

//--- rtl/beatRecords.hex
// One 14-bit sample per line: record 0 then record 1, 75 samples each.
2000
1FFE
2001
1FFF
05F0
05EE
05F2
05FA
0609
061A
062C
063A
0640
063C
0630
061E
060C
05FE
05F6
05F0
05EC
05EA
05E8
05E6
05E2
05DA
05C8
05BE
0618
0730
092E
0AC8
096A
06F4
0516
056E
05BE
05DC
05E4
05E8
05EC
05F2
05FA
0606
0616
062A
0642
065E
067C
069A
06B4
06C6
06CE
06CA
06BA
06A2
0686
0668
064A
0630
061A
060A
05FE
05F6
05F0
05EC
05EA
05E8
05E8
05E6
05E6
05E4
05E4
05E2
05E2
2000
2002
1FFD
2000
0668
0666
0664
0668
0670
067C
068C
069E
06B0
06BE
06C4
06C0
06B4
06A4
0694
0686
067C
0676
0672
0670
066E
066C
066A
0668
0666
0664
0662
0660
065E
065C
065A
0654
064A
0636
0618
05FA
06A4
0884
0AE6
0CBC
0D52
0BCC
08C0
05C8
0460
04EC
0596
0618
064A
065A
0668
067C
069A
06C2
06F4
072C
0762
078A
07A0
079C
0780
0754
071C
06E4
06B4
0692
067E
0674
066E
066A
0668
